//--- src/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

//////////////////////////////////////////////////
// cache geometry
//////////////////////////////////////////////////

// set number bits, 16 sets
`define DC_INDEX_W 4

// word-in-line bits, 4 words per line
`define DC_OFFSET_W 2

// one full line as the memory returns it
`define DC_LINE_W (32 * (1 << `DC_OFFSET_W))

`endif

//--- src/dcache_addr_pkg.sv
`include "dcache_params.svh"

package dcache_addr_pkg;

    // tag is what remains above index, word offset and byte bits
    localparam int DC_TAG_W = 32 - `DC_INDEX_W - `DC_OFFSET_W - 2;

    typedef logic [DC_TAG_W-1:0] dc_tag_t;

    typedef logic [`DC_INDEX_W-1:0] dc_index_t;

    typedef logic [`DC_OFFSET_W-1:0] dc_offset_t;

    typedef logic [31:0] dc_word_t;

    // one enable per byte lane
    typedef logic [3:0] dc_strb_t;

    typedef logic [`DC_LINE_W-1:0] dc_line_t;

endpackage

//--- src/dcache_ctrl_pkg.sv
package dcache_ctrl_pkg;

    // controller states
    // refill doubles as the response cycle after any memory transaction
    typedef enum logic [2:0] {
        idle_lookup,
        miss_req,
        miss_wait,
        refill,
        wr_req,
        wr_wait
    } dc_state_t;

    // two ways, so one bit names a way
    typedef logic dc_way_t;

endpackage

//--- src/dcache_req_buf.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_req_buf
    import dcache_addr_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       load,
    input  dc_word_t   addr,
    input  dc_word_t   wdata,
    input  dc_strb_t   wstrb,
    input  logic       we,
    output dc_tag_t    buf_tag,
    output dc_index_t  buf_index,
    output dc_offset_t buf_offset,
    output dc_word_t   buf_wdata,
    output dc_strb_t   buf_wstrb,
    output logic       buf_we,
    output logic       buf_full
);

    // byte bits are dropped, accesses are whole words
    logic [31:2] addr_q;

    always_ff @(posedge clk) begin
        if (load) begin
            addr_q    <= addr[31:2];
            buf_wdata <= wdata;
            buf_wstrb <= wstrb;
        end
    end

    // lookup is due only in the cycle right after acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            buf_full <= 1'b0;
            buf_we   <= 1'b0;
        end else begin
            buf_full <= load;
            if (load) begin
                buf_we <= we;
            end
        end
    end

    assign buf_tag    = addr_q[31:`DC_INDEX_W+`DC_OFFSET_W+2];
    assign buf_index  = addr_q[`DC_INDEX_W+`DC_OFFSET_W+1:`DC_OFFSET_W+2];
    assign buf_offset = addr_q[`DC_OFFSET_W+1:2];

endmodule

//--- src/dcache_tagv.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_tagv
    import dcache_addr_pkg::*;
    import dcache_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  dc_index_t rd_index,
    input  dc_tag_t   cmp_tag,
    input  dc_index_t wr_index,
    input  dc_tag_t   wr_tag,
    input  dc_way_t   wr_way,
    input  logic      wr_en,
    output logic      hit,
    output dc_way_t   hit_way
);

    localparam int SETS = 1 << `DC_INDEX_W;

    dc_tag_t         tag_mem [2][SETS];
    logic [SETS-1:0] valid [2];
    dc_tag_t         rd_tag [2];
    logic [1:0]      rd_valid;
    logic [1:0]      way_hit;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_way][wr_index] <= wr_tag;
        end
        for (int w = 0; w < 2; w++) begin
            rd_tag[w] <= tag_mem[w][rd_index];
        end
    end

    // valid bits, a refill is the only way a line becomes valid
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < 2; w++) begin
                valid[w] <= '0;
            end
            rd_valid <= '0;
        end else begin
            if (wr_en) begin
                valid[wr_way][wr_index] <= 1'b1;
            end
            for (int w = 0; w < 2; w++) begin
                rd_valid[w] <= valid[w][rd_index];
            end
        end
    end

    // compare the stored tags with the buffered request tag
    assign way_hit[0] = rd_valid[0] && (rd_tag[0] == cmp_tag);
    assign way_hit[1] = rd_valid[1] && (rd_tag[1] == cmp_tag);
    assign hit        = |way_hit;
    assign hit_way    = way_hit[1];

endmodule

//--- src/dcache_data.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_data
    import dcache_addr_pkg::*;
    import dcache_ctrl_pkg::*;
(
    input  logic       clk,
    input  dc_index_t  rd_index,
    input  dc_way_t    rd_way,
    input  dc_offset_t rd_offset,
    input  dc_index_t  wr_index,
    input  dc_way_t    wr_way,
    input  dc_offset_t wr_offset,
    input  dc_word_t   wr_word,
    input  dc_strb_t   wr_strb,
    input  logic       word_we,
    input  dc_line_t   refill_line,
    input  logic       line_we,
    output dc_word_t   rd_word
);

    localparam int SETS  = 1 << `DC_INDEX_W;
    localparam int WORDS = `DC_LINE_W / 32;

    dc_word_t mem [2][SETS][WORDS];
    dc_word_t rd_q [2][WORDS];

    //////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////

    // refill writes the whole line, a store hit only the strobed bytes
    always_ff @(posedge clk) begin
        if (line_we) begin
            for (int i = 0; i < WORDS; i++) begin
                mem[wr_way][wr_index][i] <= refill_line[32*i +: 32];
            end
        end else if (word_we) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_way][wr_index][wr_offset][8*b +: 8] <= wr_word[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // read port
    //////////////////////////////////////////////////

    // both ways read every cycle, the way is picked after the compare
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            for (int i = 0; i < WORDS; i++) begin
                rd_q[w][i] <= mem[w][rd_index][i];
            end
        end
    end

    assign rd_word = rd_q[rd_way][rd_offset];

endmodule

//--- src/dcache_lru.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_lru
    import dcache_addr_pkg::*;
    import dcache_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  dc_index_t index,
    input  logic      touch,
    input  dc_way_t   touch_way,
    output dc_way_t   victim
);

    localparam int SETS = 1 << `DC_INDEX_W;

    // each bit names the least recently used way of its set
    logic [SETS-1:0] lru_bits;

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_bits <= '0;
        end else if (touch) begin
            lru_bits[index] <= ~touch_way;
        end
    end

    assign victim = lru_bits[index];

endmodule

//--- src/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_ctrl
    import dcache_addr_pkg::*;
    import dcache_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid,
    input  logic       buf_full,
    input  logic       buf_we,
    input  logic       hit,
    input  dc_way_t    hit_way,
    input  dc_way_t    victim,
    input  logic       mem_addr_ok,
    input  logic       mem_data_ok,
    input  dc_line_t   mem_rline,
    input  dc_offset_t buf_offset,
    output logic       req_ready,
    output logic       buf_load,
    output logic       resp_valid,
    output logic       mem_req,
    output logic       mem_wr,
    output logic       tag_we,
    output logic       word_we,
    output logic       line_we,
    output logic       lru_touch,
    output dc_way_t    sel_way,
    output dc_word_t   refill_word
);

    dc_state_t state;
    dc_state_t next_state;
    logic      lookup;
    logic      rd_hit;
    logic      miss_done;

    //////////////////////////////////////////////////
    // decode of the current cycle
    //////////////////////////////////////////////////

    assign lookup = (state == idle_lookup) && buf_full;
    assign rd_hit = lookup && hit && !buf_we;

    // line arrives, possibly in the same cycle as the address handshake
    assign miss_done = mem_data_ok &&
                       ((state == miss_wait) || ((state == miss_req) && mem_addr_ok));

    always_comb begin
        next_state = state;
        case (state)
            idle_lookup: begin
                if (lookup) begin
                    if (buf_we) begin
                        next_state = wr_req;
                    end else if (!hit) begin
                        next_state = miss_req;
                    end
                end
            end
            miss_req: begin
                if (mem_addr_ok) begin
                    next_state = mem_data_ok ? refill : miss_wait;
                end
            end
            miss_wait: begin
                if (mem_data_ok) begin
                    next_state = refill;
                end
            end
            wr_req: begin
                if (mem_addr_ok) begin
                    next_state = mem_data_ok ? refill : wr_wait;
                end
            end
            wr_wait: begin
                if (mem_data_ok) begin
                    next_state = refill;
                end
            end
            refill: begin
                next_state = idle_lookup;
            end
            default: begin
                next_state = idle_lookup;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle_lookup;
        end else begin
            state <= next_state;
        end
    end

    // requested word kept for the response cycle
    always_ff @(posedge clk) begin
        if (miss_done) begin
            refill_word <= mem_rline[32*buf_offset +: 32];
        end
    end

    //////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////

    // a read hit keeps the pipe open, anything else closes it until the response
    assign req_ready  = ((state == idle_lookup) && (!buf_full || rd_hit)) || (state == refill);
    assign buf_load   = req_valid && req_ready;
    assign resp_valid = rd_hit || (state == refill);

    assign mem_req = (state == miss_req) || (state == wr_req);
    assign mem_wr  = (state == wr_req);

    // write hit merges into the array, a write miss allocates nothing
    assign word_we   = lookup && buf_we && hit;
    assign line_we   = miss_done;
    assign tag_we    = miss_done;
    assign lru_touch = (lookup && hit) || miss_done;
    assign sel_way   = (state == idle_lookup) ? hit_way : victim;

endmodule

//--- src/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_top
    import dcache_addr_pkg::*;
    import dcache_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    input  logic     req_we,
    input  dc_word_t req_addr,
    input  dc_word_t req_wdata,
    input  dc_strb_t req_wstrb,
    input  logic     mem_addr_ok,
    input  logic     mem_data_ok,
    input  dc_line_t mem_rline,
    output logic     req_ready,
    output logic     resp_valid,
    output dc_word_t resp_rdata,
    output logic     mem_req,
    output logic     mem_wr,
    output dc_word_t mem_addr,
    output dc_word_t mem_wdata,
    output dc_strb_t mem_wstrb
);

    logic       buf_load;
    logic       buf_full;
    logic       buf_we;
    dc_tag_t    buf_tag;
    dc_index_t  buf_index;
    dc_offset_t buf_offset;
    dc_word_t   buf_wdata;
    dc_strb_t   buf_wstrb;
    dc_index_t  rd_index;
    logic       hit;
    dc_way_t    hit_way;
    dc_way_t    victim;
    dc_way_t    sel_way;
    logic       tag_we;
    logic       word_we;
    logic       line_we;
    logic       lru_touch;
    dc_word_t   rd_word;
    dc_word_t   refill_word;

    // arrays follow the incoming index on acceptance, else hold the buffered set
    assign rd_index = buf_load ? req_addr[`DC_INDEX_W+`DC_OFFSET_W+1:`DC_OFFSET_W+2]
                               : buf_index;

    dcache_req_buf u_req_buf (
        .clk        (clk),
        .rst        (rst),
        .load       (buf_load),
        .addr       (req_addr),
        .wdata      (req_wdata),
        .wstrb      (req_wstrb),
        .we         (req_we),
        .buf_tag    (buf_tag),
        .buf_index  (buf_index),
        .buf_offset (buf_offset),
        .buf_wdata  (buf_wdata),
        .buf_wstrb  (buf_wstrb),
        .buf_we     (buf_we),
        .buf_full   (buf_full)
    );

    dcache_tagv u_tagv (
        .clk      (clk),
        .rst      (rst),
        .rd_index (rd_index),
        .cmp_tag  (buf_tag),
        .wr_index (buf_index),
        .wr_tag   (buf_tag),
        .wr_way   (sel_way),
        .wr_en    (tag_we),
        .hit      (hit),
        .hit_way  (hit_way)
    );

    dcache_data u_data (
        .clk         (clk),
        .rd_index    (rd_index),
        .rd_way      (sel_way),
        .rd_offset   (buf_offset),
        .wr_index    (buf_index),
        .wr_way      (sel_way),
        .wr_offset   (buf_offset),
        .wr_word     (buf_wdata),
        .wr_strb     (buf_wstrb),
        .word_we     (word_we),
        .refill_line (mem_rline),
        .line_we     (line_we),
        .rd_word     (rd_word)
    );

    dcache_lru u_lru (
        .clk       (clk),
        .rst       (rst),
        .index     (buf_index),
        .touch     (lru_touch),
        .touch_way (sel_way),
        .victim    (victim)
    );

    dcache_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .buf_full    (buf_full),
        .buf_we      (buf_we),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim      (victim),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_rline   (mem_rline),
        .buf_offset  (buf_offset),
        .req_ready   (req_ready),
        .buf_load    (buf_load),
        .resp_valid  (resp_valid),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .tag_we      (tag_we),
        .word_we     (word_we),
        .line_we     (line_we),
        .lru_touch   (lru_touch),
        .sel_way     (sel_way),
        .refill_word (refill_word)
    );

    // buf_full only in the lookup cycle, otherwise the response follows a refill
    assign resp_rdata = buf_full ? rd_word : refill_word;

    // line reads are aligned, writes carry the word address
    assign mem_addr  = {buf_tag, buf_index, mem_wr ? buf_offset : dc_offset_t'(0), 2'b00};
    assign mem_wdata = buf_wdata;
    assign mem_wstrb = buf_wstrb;

endmodule

//--- tb/dcache_props.sv
`timescale 1ns/1ps

module dcache_props (
    input logic        clk,
    input logic        rst,
    input logic        req_valid,
    input logic        req_ready,
    input logic        resp_valid,
    input logic        mem_req,
    input logic        mem_wr,
    input logic [31:0] mem_addr,
    input logic [31:0] mem_wdata,
    input logic [3:0]  mem_wstrb,
    input logic        mem_addr_ok
);

    // accepted requests still waiting for resp_valid
    int outstanding;

    always @(posedge clk) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(req_valid && req_ready) - int'(resp_valid);
        end
    end

    a_mem_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_addr_ok |=> mem_req && $stable(mem_wr) && $stable(mem_addr)
            && $stable(mem_wdata) && $stable(mem_wstrb))
        else $error("memory request changed before mem_addr_ok");

    a_read_aligned: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_wr |-> mem_addr[3:0] == 4'h0)
        else $error("line read address not aligned");

    a_resp_owned: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> outstanding > 0)
        else $error("resp_valid with nothing outstanding");

    a_after_reset: assert property (@(posedge clk)
        $past(rst) && !rst |-> req_ready && !mem_req && !resp_valid)
        else $error("bad port state after reset");

endmodule

bind dcache_top dcache_props u_props (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .resp_valid  (resp_valid),
    .mem_req     (mem_req),
    .mem_wr      (mem_wr),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_wstrb   (mem_wstrb),
    .mem_addr_ok (mem_addr_ok)
);

//--- tb/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_tb;

    localparam int MEM_WORDS = 1024;
    localparam int N_REQ     = 320;
    localparam int LIMIT     = 200 + 20 * N_REQ;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    logic                  req_we;
    logic [31:0]           req_addr;
    logic [31:0]           req_wdata;
    logic [3:0]            req_wstrb;
    logic                  mem_addr_ok;
    logic                  mem_data_ok;
    logic [`DC_LINE_W-1:0] mem_rline;
    logic                  req_ready;
    logic                  resp_valid;
    logic [31:0]           resp_rdata;
    logic                  mem_req;
    logic                  mem_wr;
    logic [31:0]           mem_addr;
    logic [31:0]           mem_wdata;
    logic [3:0]            mem_wstrb;

    // shadow memory behind the port, and the reference state
    logic [31:0] shadow [MEM_WORDS];
    logic [31:0] ref_mem [MEM_WORDS];
    logic [23:0] ref_tag [2][16];
    logic        ref_valid [2][16];
    logic        ref_lru [16];
    int          ref_reads;
    int          ref_writes;

    // outstanding requests, oldest first
    logic        q_we [$];
    logic        q_hit [$];
    logic [31:0] q_exp [$];
    time         q_time [$];

    int          errors;
    int          cycle;
    int          rd_count;
    int          wr_count;
    int          phase;
    int          armed;
    int          addr_cnt;
    int          data_cnt;
    logic        lat_wr;
    logic [31:0] lat_addr;
    logic [31:0] exp_wr_addr;
    logic [31:0] exp_wr_data;
    logic [3:0]  exp_wr_strb;
    logic [31:0] exp_rd_addr;

    dcache_top UUT (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] fill_word(input int i);
        return (32'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] nw,
                                          input logic [3:0] strb);
        logic [31:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) r[8*b +: 8] = nw[8*b +: 8];
        end
        return r;
    endfunction

    // write-through, no write allocate, one LRU bit naming the older way
    function automatic logic [31:0] ref_access(input logic we, input logic [31:0] addr,
                                               input logic [31:0] wdata,
                                               input logic [3:0] strb, output logic hit);
        int   idx;
        int   w;
        logic way;
        idx = int'(addr[7:4]);
        w   = int'(addr[11:2]);
        hit = 1'b0;
        way = 1'b0;
        for (int k = 0; k < 2; k++) begin
            if (ref_valid[k][idx] && ref_tag[k][idx] == addr[31:8]) begin
                hit = 1'b1;
                way = k[0];
            end
        end
        if (hit) ref_lru[idx] = ~way;
        if (we) begin
            ref_mem[w] = merge(ref_mem[w], wdata, strb);
            ref_writes++;
            return 32'h0;
        end
        if (!hit) begin
            way = ref_lru[idx];
            ref_tag[way][idx]   = addr[31:8];
            ref_valid[way][idx] = 1'b1;
            ref_lru[idx]        = ~way;
            ref_reads++;
        end
        return ref_mem[w];
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // hold the request until accepted, then record what should come back
    task automatic send(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                        input logic [3:0] strb);
        logic        hit;
        logic [31:0] exp;
        req_valid = 1'b1;
        req_we    = we;
        req_addr  = addr;
        req_wdata = wdata;
        req_wstrb = strb;
        do @(posedge clk); while (!req_ready);
        exp = ref_access(we, addr, wdata, strb, hit);
        if (we) begin
            exp_wr_addr = {addr[31:2], 2'b00};
            exp_wr_data = wdata;
            exp_wr_strb = strb;
        end else begin
            exp_rd_addr = {addr[31:4], 4'h0};
        end
        q_we.push_back(we);
        q_hit.push_back(hit);
        q_exp.push_back(exp);
        q_time.push_back($time);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic drain();
        while (q_we.size() != 0) @(posedge clk);
        @(negedge clk);
    endtask

    //////////////////////////////////////////////////
    // memory model
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        if (rst) begin
            phase = 0;
            armed = 0;
        end else if (phase == 0) begin
            if (mem_req) begin
                if (armed == 0) begin
                    armed    = 1;
                    addr_cnt = int'($urandom % 5);
                end
                if (addr_cnt == 0) begin
                    mem_addr_ok = 1'b1;
                    armed       = 0;
                    lat_wr      = mem_wr;
                    lat_addr    = mem_addr;
                    if (mem_wr) begin
                        check("mem_addr", mem_addr, exp_wr_addr);
                        check("mem_wdata", mem_wdata, exp_wr_data);
                        check("mem_wstrb", {28'h0, mem_wstrb}, {28'h0, exp_wr_strb});
                        shadow[int'(mem_addr[11:2])] =
                            merge(shadow[int'(mem_addr[11:2])], mem_wdata, mem_wstrb);
                    end else begin
                        check("mem_addr", mem_addr, exp_rd_addr);
                    end
                    data_cnt = int'($urandom % 5);
                    phase    = 1;
                end else begin
                    addr_cnt--;
                end
            end
        end
        if (phase == 1) begin
            if (data_cnt == 0) begin
                mem_data_ok = 1'b1;
                phase       = 0;
                if (!lat_wr) begin
                    for (int k = 0; k < 4; k++) begin
                        mem_rline[32*k +: 32] = shadow[int'({lat_addr[11:4], 2'b00}) + k];
                    end
                end
            end else begin
                data_cnt--;
            end
        end
    end

    //////////////////////////////////////////////////
    // compare process and port counters
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        int lat;
        if (!rst && mem_req && mem_addr_ok) begin
            if (mem_wr) wr_count++;
            else rd_count++;
        end
        if (!rst && resp_valid) begin
            if (q_we.size() == 0) begin
                errors++;
                $display("ERROR t=%0t a response arrived with no request outstanding", $time);
            end else begin
                lat = int'(($time - q_time[0]) / 10);
                if (!q_we[0]) check("resp_rdata", resp_rdata, q_exp[0]);
                if (!q_we[0] && q_hit[0]) check("hit_latency", 32'(lat), 32'd1);
                else check("miss_latency_gt1", {31'h0, lat > 1}, 32'd1);
                void'(q_we.pop_front());
                void'(q_hit.pop_front());
                void'(q_exp.pop_front());
                void'(q_time.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle > LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        int r0;
        int w0;
        void'($urandom(32'he71a));
        clk = 1'b0;
        rst = 1'b1;
        req_valid = 1'b0;
        req_we = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        req_wstrb = '0;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rline = '0;
        errors = 0;
        cycle = 0;
        rd_count = 0;
        wr_count = 0;
        ref_reads = 0;
        ref_writes = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i]  = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        for (int s = 0; s < 16; s++) begin
            ref_valid[0][s] = 1'b0;
            ref_valid[1][s] = 1'b0;
            ref_lru[s] = 1'b0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check("req_ready", {31'h0, req_ready}, 32'd1);
        check("mem_req", {31'h0, mem_req}, 32'd0);

        // first read fills one line
        send(1'b0, 32'h100, 32'h0, 4'h0);
        drain();
        check("line_reads_first", 32'(rd_count), 32'd1);

        // hits back to back on the filled line
        for (int k = 0; k < 4; k++) send(1'b0, 32'h100 + 32'(4 * k), 32'h0, 4'h0);
        drain();
        check("line_reads_hits", 32'(rd_count), 32'd1);

        // partial write on a hit, then read the merged word
        send(1'b1, 32'h104, 32'hdead_beef, 4'b0101);
        drain();
        check("mem_writes", 32'(wr_count), 32'd1);
        send(1'b0, 32'h104, 32'h0, 4'h0);
        drain();

        // write miss allocates nothing
        r0 = rd_count;
        send(1'b1, 32'h808, 32'h1234_5678, 4'b1100);
        drain();
        check("write_miss_fill", 32'(rd_count - r0), 32'd0);
        send(1'b0, 32'h808, 32'h0, 4'h0);
        drain();
        check("read_after_write_miss", 32'(rd_count - r0), 32'd1);

        // A B A C in set 4, then A hits and B misses
        r0 = rd_count;
        send(1'b0, 32'h040, 32'h0, 4'h0);
        send(1'b0, 32'h440, 32'h0, 4'h0);
        send(1'b0, 32'h040, 32'h0, 4'h0);
        send(1'b0, 32'h840, 32'h0, 4'h0);
        drain();
        check("lru_fills", 32'(rd_count - r0), 32'd3);
        send(1'b0, 32'h040, 32'h0, 4'h0);
        drain();
        check("lru_a_hit", 32'(rd_count - r0), 32'd3);
        send(1'b0, 32'h440, 32'h0, 4'h0);
        drain();
        check("lru_b_miss", 32'(rd_count - r0), 32'd4);

        // random mix over a 1 KB window
        for (int n = 0; n < 300; n++) begin
            w0 = int'($urandom % 3);
            send(w0 == 0, {22'h0, 8'($urandom), 2'b00}, $urandom, 4'($urandom));
            repeat (int'($urandom % 3)) @(negedge clk);
        end
        drain();
        repeat (4) @(negedge clk);
        check("line_reads_total", 32'(rd_count), 32'(ref_reads));
        check("mem_writes_total", 32'(wr_count), 32'(ref_writes));

        $display("errors: %0d, line reads: %0d, memory writes: %0d",
                 errors, rd_count, wr_count);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- dcache.f
+incdir+src
src/dcache_addr_pkg.sv
src/dcache_ctrl_pkg.sv
src/dcache_req_buf.sv
src/dcache_tagv.sv
src/dcache_data.sv
src/dcache_lru.sv
src/dcache_ctrl.sv
src/dcache_top.sv
tb/dcache_props.sv
tb/dcache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module dcache_tb -f dcache.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vdcache_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1
